/* Makefile */
# Verilator build and run for the single-cycle MIPS core

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
LOG       ?= sim.log
OBJDIR    ?= obj_dir
FILELIST  ?= files.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(OBJDIR) -f $(FILELIST)

# the log decides, the simulator status alone does not
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* files.f */
src/isaPkg.sv
src/corePkg.sv
src/instrDecoder.sv
src/regFile.sv
src/nextPcUnit.sv
src/executeUnit.sv
src/mipsCore.sv
test/mipsCore_sva.sv
test/mipsCoreTb.sv

/* src/corePkg.sv */
// core datapath types: ALU operation, control word, data memory request
package corePkg;

  // ====================
  // data memory sizing
  // ====================
  // word address width of the data memory port
  // an instance parameter may shrink it but never grow it
  localparam int defaultDmemAddrWidth = 7;

  // ====================
  // ALU operations
  // ====================
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpSel;

  // ====================
  // decoded control, all zero is a no-op
  // ====================
  typedef struct packed {
    logic    regDst;    // write rd instead of rt
    logic    aluSrc;    // second operand is the immediate
    logic    memToReg;  // write back the load data
    logic    regWrite;
    logic    memWrite;
    logic    branch;    // beq
    logic    jump;      // j and jal
    logic    link;      // jal, pc+4 into r31
    logic    jumpReg;   // jr
    aluOpSel aluOp;
  } ctrlWord;

  // chip-select style request, en and write active high
  typedef struct packed {
    logic                            en;
    logic                            write;
    logic [defaultDmemAddrWidth-1:0] addr;
    logic [31:0]                     wdata;
  } dmemReq;

endpackage

/* src/executeUnit.sv */
// execute stage: operand select, ALU, data memory request, write-back, branch
`timescale 1ns/1ps

module executeUnit #(
  // must not exceed corePkg::defaultDmemAddrWidth
  parameter int dmemAddrWidth = corePkg::defaultDmemAddrWidth
) (
  input  isaPkg::instrWord instr,
  input  corePkg::ctrlWord ctrl,
  input  logic [31:0]      rsData,
  input  logic [31:0]      rtData,
  input  logic [31:0]      pcPlus4,
  input  logic [31:0]      dmemRdata,
  output corePkg::dmemReq  dmem,
  output logic             wbWrite,
  output logic [4:0]       wbAddr,
  output logic [31:0]      wbData,
  output logic             branchTaken
);

  logic [31:0] immExt;
  logic [31:0] opB;
  logic [31:0] aluResult;
  logic        aluZero;

  // ====================
  // operands
  // ====================
  assign immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};
  // immediate for addi, lw, sw
  assign opB = ctrl.aluSrc ? immExt : rtData;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (ctrl.aluOp)
      corePkg::aluAdd: aluResult = rsData + opB;
      corePkg::aluSub: aluResult = rsData - opB;
      corePkg::aluAnd: aluResult = rsData & opB;
      corePkg::aluOr:  aluResult = rsData | opB;
      // signed compare
      corePkg::aluSlt: aluResult = ($signed(rsData) < $signed(opB)) ? 32'd1 : 32'd0;
      default:         aluResult = '0;
    endcase
  end

  assign aluZero = (aluResult == 32'd0);
  // beq only, difference of rs and rt
  assign branchTaken = ctrl.branch & aluZero;

  // ====================
  // data memory request
  // ====================
  always_comb begin
    dmem       = '0;
    // any access, load or store
    dmem.en    = ctrl.memWrite | ctrl.memToReg;
    dmem.write = ctrl.memWrite;
    // byte address to word address
    dmem.addr[dmemAddrWidth-1:0] = aluResult[2 +: dmemAddrWidth];
    dmem.wdata = rtData;
  end

  // ====================
  // write-back
  // ====================
  // r31 for jal, rd for R-type, rt otherwise
  always_comb begin
    if (ctrl.link) begin
      wbAddr = 5'd31;
    end else if (ctrl.regDst) begin
      wbAddr = instr.rType.rd;
    end else begin
      wbAddr = instr.rType.rt;
    end
  end

  // link value, then load data, then ALU
  always_comb begin
    if (ctrl.link) begin
      wbData = pcPlus4;
    end else if (ctrl.memToReg) begin
      wbData = dmemRdata;
    end else begin
      wbData = aluResult;
    end
  end

  // r0 writes dropped here, the register file trusts wbWrite
  assign wbWrite = ctrl.regWrite && (wbAddr != 5'd0);

endmodule

/* src/instrDecoder.sv */
// instruction decoder: opcode and funct to the core control word
`timescale 1ns/1ps

module instrDecoder (
  input  isaPkg::instrWord instr,
  output corePkg::ctrlWord ctrl
);

  // ====================
  // main decode
  // ====================
  always_comb begin
    // unknown codes fall through as all zero
    ctrl = '0;
    case (instr.rType.opcode)
      isaPkg::opSpecial: begin
        // R-type, funct picks the operation
        case (instr.rType.funct)
          isaPkg::fnAdd: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = corePkg::aluAdd;
          end
          isaPkg::fnSub: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = corePkg::aluSub;
          end
          isaPkg::fnAnd: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = corePkg::aluAnd;
          end
          isaPkg::fnOr: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = corePkg::aluOr;
          end
          isaPkg::fnSlt: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = corePkg::aluSlt;
          end
          // no write back, target is rs
          isaPkg::fnJr: ctrl.jumpReg = 1'b1;
          // sll $0 and other shifts land here
          default: ctrl = '0;
        endcase
      end
      isaPkg::opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = corePkg::aluAdd;
      end
      isaPkg::opLw: begin
        // address is rs + imm
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = corePkg::aluAdd;
      end
      isaPkg::opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = corePkg::aluAdd;
      end
      isaPkg::opBeq: begin
        // equal when rs - rt is zero
        ctrl.branch = 1'b1;
        ctrl.aluOp  = corePkg::aluSub;
      end
      isaPkg::opJ: ctrl.jump = 1'b1;
      isaPkg::opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

/* src/isaPkg.sv */
// MIPS32 subset encodings: opcodes, R-type function codes, instruction word views
package isaPkg;

  // ====================
  // primary opcodes, bits 31:26
  // ====================
  // R-type group, decoded further by funct
  localparam logic [5:0] opSpecial = 6'h00;
  localparam logic [5:0] opJ       = 6'h02;
  localparam logic [5:0] opJal     = 6'h03;
  localparam logic [5:0] opBeq     = 6'h04;
  localparam logic [5:0] opAddi    = 6'h08;
  localparam logic [5:0] opLw      = 6'h23;
  localparam logic [5:0] opSw      = 6'h2b;

  // ====================
  // function codes, bits 5:0 of R-type
  // ====================
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;
  // jump through register rs
  localparam logic [5:0] fnJr  = 6'h08;

  // ====================
  // instruction formats
  // ====================
  // register format, three register fields
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeFmt;

  // immediate format, also used by beq, lw and sw
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeFmt;

  // jump format, 26-bit word target
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jTypeFmt;

  // one 32-bit word, three ways to read it
  typedef union packed {
    rTypeFmt rType;
    iTypeFmt iType;
    jTypeFmt jType;
  } instrWord;

endpackage

/* src/mipsCore.sv */
// single-cycle MIPS core top: decoder, register file, execute unit, pc unit
`timescale 1ns/1ps

module mipsCore #(
  parameter int dmemAddrWidth = corePkg::defaultDmemAddrWidth
) (
  input  logic             clk,
  input  logic             rst,
  // instruction memory, read in the same cycle
  output logic [31:0]      imemAddr,
  input  isaPkg::instrWord instr,
  // data memory, written on the rising edge
  output corePkg::dmemReq  dmem,
  input  logic [31:0]      dmemRdata,
  // retiring register write
  output logic             wbWrite,
  output logic [4:0]       wbAddr,
  output logic [31:0]      wbData
);

  corePkg::ctrlWord ctrl;
  logic [31:0]      rsData;
  logic [31:0]      rtData;
  logic [31:0]      pcPlus4;
  logic             branchTaken;

  // ====================
  // decode and register read, side by side
  // ====================
  instrDecoder decoder_i (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // write port fed back from the write-back ports
  regFile regFile_i (
    .clk    (clk),
    .rst    (rst),
    .rsAddr (instr.rType.rs),
    .rtAddr (instr.rType.rt),
    .wrAddr (wbAddr),
    .wrEn   (wbWrite),
    .wrData (wbData),
    .rsData (rsData),
    .rtData (rtData)
  );

  // ====================
  // execute and next pc
  // ====================
  executeUnit #(
    .dmemAddrWidth (dmemAddrWidth)
  ) execute_i (
    .instr       (instr),
    .ctrl        (ctrl),
    .rsData      (rsData),
    .rtData      (rtData),
    .pcPlus4     (pcPlus4),
    .dmemRdata   (dmemRdata),
    .dmem        (dmem),
    .wbWrite     (wbWrite),
    .wbAddr      (wbAddr),
    .wbData      (wbData),
    .branchTaken (branchTaken)
  );

  // pc drives the fetch address directly
  nextPcUnit nextPc_i (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .ctrl        (ctrl),
    .rsData      (rsData),
    .branchTaken (branchTaken),
    .pc          (imemAddr),
    .pcPlus4     (pcPlus4)
  );

endmodule

/* src/nextPcUnit.sv */
// program counter register and next-pc selection
`timescale 1ns/1ps

module nextPcUnit (
  input  logic             clk,
  input  logic             rst,
  input  isaPkg::instrWord instr,
  input  corePkg::ctrlWord ctrl,
  input  logic [31:0]      rsData,
  input  logic             branchTaken,
  output logic [31:0]      pc,
  output logic [31:0]      pcPlus4
);

  logic [31:0] branchOffset;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  // ====================
  // candidate targets
  // ====================
  // sequential, also the link value for jal
  assign pcPlus4 = pc + 32'd4;

  // sign-extended word offset
  assign branchOffset = {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;

  // region of pc+4, low 28 bits from the target field
  assign jumpTarget = {pcPlus4[31:28], instr.jType.target, 2'b00};

  // ====================
  // selection
  // ====================
  // jump, then jr, then taken beq, else fall through
  always_comb begin
    if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.jumpReg) begin
      nextPc = rsData;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // ====================
  // pc register
  // ====================
  // fetch starts at word 0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

/* src/regFile.sv */
// register file: 32 x 32 bits, two combinational reads, one clocked write
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  logic [4:0]  wrAddr,
  input  logic        wrEn,
  input  logic [31:0] wrData,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  // ====================
  // storage
  // ====================
  logic [31:0] regs [32];

  // whole file cleared on reset
  // write enable arrives already masked for r0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ====================
  // read ports
  // ====================
  // r0 hardwired to zero
  always_comb begin
    if (rsAddr == 5'd0) begin
      rsData = '0;
    end else begin
      rsData = regs[rsAddr];
    end
  end

  // same for the rt port
  always_comb begin
    if (rtAddr == 5'd0) begin
      rtData = '0;
    end else begin
      rtData = regs[rtAddr];
    end
  end

  // new value visible after the write edge, no bypass

endmodule

/* test/mipsCoreTb.sv */
// testbench for mipsCore: clock, reset, program table, data memory model, checks, watchdog
`timescale 1ns/1ps

module mipsCoreTb;

  localparam int clkPeriod = 100;
  localparam int numRows = 21;
  localparam int addrWidth = corePkg::defaultDmemAddrWidth;
  localparam int memWords = 2 ** addrWidth;

  // one program step and the write-back it must produce
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbWrite;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        fromMem;  // expected data is the loaded word
  } stimRow;

  logic             clk;
  logic             rst;
  logic [31:0]      imemAddr;
  isaPkg::instrWord instr;
  corePkg::dmemReq  dmem;
  logic [31:0]      dmemRdata;
  logic             wbWrite;
  logic [4:0]       wbAddr;
  logic [31:0]      wbData;

  stimRow      rows [numRows];
  int          rowCount;
  int          errCount;
  int          checkCount;
  integer      seed;
  logic [31:0] dataMem [memWords];
  logic [31:0] memShadow [memWords];
  logic [31:0] regShadow [32];

  mipsCore #(
    .dmemAddrWidth (addrWidth)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .imemAddr  (imemAddr),
    .instr     (instr),
    .dmem      (dmem),
    .dmemRdata (dmemRdata),
    .wbWrite   (wbWrite),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  // ====================
  // clock, memory model
  // ====================
  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // combinational read, store on the rising edge
  assign dmemRdata = dataMem[dmem.addr];

  always @(posedge clk) begin
    if (dmem.en && dmem.write) begin
      dataMem[dmem.addr] = dmem.wdata;
    end
  end

  // ====================
  // program encoding
  // ====================
  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {isaPkg::opSpecial, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic addRow(input logic [31:0] word, input logic [31:0] pc, input logic wr,
                        input logic [4:0] addr, input logic [31:0] data, input logic mem);
    rows[rowCount] = '{word, pc, wr, addr, data, mem};
    rowCount++;
  endtask

  // r1 = 0xf0 and r2 = -0x33, so signed and unsigned slt disagree
  task automatic buildTable();
    rowCount = 0;
    addRow(encodeI(isaPkg::opAddi, 5'd0, 5'd1, 16'h00f0), 32'h00, 1'b1, 5'd1, 32'h0000_00f0, 1'b0);
    addRow(encodeI(isaPkg::opAddi, 5'd0, 5'd2, 16'hffcd), 32'h04, 1'b1, 5'd2, 32'hffff_ffcd, 1'b0);
    addRow(encodeR(5'd1, 5'd2, 5'd3, isaPkg::fnAdd), 32'h08, 1'b1, 5'd3, 32'h0000_00bd, 1'b0);
    addRow(encodeR(5'd1, 5'd2, 5'd4, isaPkg::fnSub), 32'h0c, 1'b1, 5'd4, 32'h0000_0123, 1'b0);
    addRow(encodeR(5'd1, 5'd2, 5'd5, isaPkg::fnAnd), 32'h10, 1'b1, 5'd5, 32'h0000_00c0, 1'b0);
    addRow(encodeR(5'd1, 5'd2, 5'd6, isaPkg::fnOr), 32'h14, 1'b1, 5'd6, 32'hffff_fffd, 1'b0);
    addRow(encodeR(5'd1, 5'd2, 5'd7, isaPkg::fnSlt), 32'h18, 1'b1, 5'd7, 32'h0000_0000, 1'b0);
    addRow(encodeR(5'd2, 5'd1, 5'd8, isaPkg::fnSlt), 32'h1c, 1'b1, 5'd8, 32'h0000_0001, 1'b0);
    // write to r0 is dropped, then r0 reads back zero
    addRow(encodeI(isaPkg::opAddi, 5'd1, 5'd0, 16'h0007), 32'h20, 1'b0, 5'd0, 32'h0, 1'b0);
    addRow(encodeR(5'd0, 5'd1, 5'd9, isaPkg::fnAdd), 32'h24, 1'b1, 5'd9, 32'h0000_00f0, 1'b0);
    // store then load at 0xf8, then an untouched word
    addRow(encodeI(isaPkg::opSw, 5'd1, 5'd3, 16'h0008), 32'h28, 1'b0, 5'd0, 32'h0, 1'b0);
    addRow(encodeI(isaPkg::opLw, 5'd1, 5'd10, 16'h0008), 32'h2c, 1'b1, 5'd10, 32'h0, 1'b1);
    addRow(encodeI(isaPkg::opLw, 5'd0, 5'd11, 16'h0040), 32'h30, 1'b1, 5'd11, 32'h0, 1'b1);
    // taken beq skips two words, the next one falls through
    addRow(encodeI(isaPkg::opBeq, 5'd1, 5'd9, 16'h0002), 32'h34, 1'b0, 5'd0, 32'h0, 1'b0);
    addRow(encodeI(isaPkg::opBeq, 5'd1, 5'd2, 16'h0005), 32'h40, 1'b0, 5'd0, 32'h0, 1'b0);
    addRow(encodeJ(isaPkg::opJ, 26'h20), 32'h44, 1'b0, 5'd0, 32'h0, 1'b0);
    addRow(encodeJ(isaPkg::opJal, 26'h30), 32'h80, 1'b1, 5'd31, 32'h0000_0084, 1'b0);
    addRow(encodeR(5'd31, 5'd0, 5'd12, isaPkg::fnAdd), 32'hc0, 1'b1, 5'd12, 32'h0000_0084, 1'b0);
    addRow(encodeR(5'd31, 5'd0, 5'd0, isaPkg::fnJr), 32'hc4, 1'b0, 5'd0, 32'h0, 1'b0);
    // opcode 0x3f is not decoded
    addRow(encodeI(6'h3f, 5'd1, 5'd3, 16'h0010), 32'h84, 1'b0, 5'd0, 32'h0, 1'b0);
    addRow(encodeI(isaPkg::opAddi, 5'd0, 5'd13, 16'h0001), 32'h88, 1'b1, 5'd13, 32'h1, 1'b0);
  endtask

  // ====================
  // checks
  // ====================
  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    isaPkg::instrWord       word;
    stimRow                 row;
    logic                   isLoad;
    logic                   isStore;
    logic [31:0]            effAddr;
    logic [31:0]            expData;
    logic [addrWidth-1:0]   wordAddr;
    errCount = 0;
    checkCount = 0;
    seed = 32'h4380_6f94;
    rst = 1'b0;
    instr = '0;
    for (int i = 0; i < memWords; i++) begin
      dataMem[i] = $random(seed);
      memShadow[i] = dataMem[i];
    end
    for (int i = 0; i < 32; i++) begin
      regShadow[i] = '0;
    end
    buildTable();
    repeat (8) @(negedge clk);
    rst = 1'b1;
    // one instruction per cycle, pc checked before the word is driven
    for (int i = 0; i < numRows; i++) begin
      row = rows[i];
      word = row.instr;
      checkWord("imemAddr", imemAddr, row.pc);
      instr = word;
      #10;
      isLoad = (word.iType.opcode == isaPkg::opLw);
      isStore = (word.iType.opcode == isaPkg::opSw);
      effAddr = regShadow[word.iType.rs] + {{16{word.iType.imm[15]}}, word.iType.imm};
      wordAddr = effAddr[2 +: addrWidth];
      checkBit("wbWrite", wbWrite, row.wbWrite);
      checkBit("dmem.en", dmem.en, isLoad | isStore);
      checkBit("dmem.write", dmem.write, isStore);
      if (isLoad | isStore) begin
        checkWord("dmem.addr", 32'(dmem.addr), 32'(wordAddr));
      end
      if (isStore) begin
        checkWord("dmem.wdata", dmem.wdata, regShadow[word.iType.rt]);
        memShadow[wordAddr] = regShadow[word.iType.rt];
      end
      if (row.wbWrite) begin
        expData = row.fromMem ? memShadow[wordAddr] : row.wbData;
        checkWord("wbAddr", 32'(wbAddr), 32'(row.wbAddr));
        checkWord("wbData", wbData, expData);
        regShadow[row.wbAddr] = expData;
      end
      @(negedge clk);
    end
    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // table length plus reset and margin
  initial begin
    #((numRows + 20) * clkPeriod);
    $display("watchdog expired before the program table finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* test/mipsCore_sva.sv */
// concurrent port assertions for mipsCore and their bind
`timescale 1ns/1ps

module mipsCoreSva (
  input logic            clk,
  input logic            rst,
  input logic [31:0]     imemAddr,
  input corePkg::dmemReq dmem,
  input logic            wbWrite,
  input logic [4:0]      wbAddr
);

  // ====================
  // fetch address
  // ====================
  wordAligned: assert property (@(posedge clk) disable iff (!rst) imemAddr[1:0] == 2'b00)
    else $error("imemAddr is not word aligned");

  // first fetch after reset at word 0
  startAtZero: assert property (@(posedge clk) $rose(rst) |-> imemAddr == 32'd0)
    else $error("imemAddr is not zero after reset release");

  // ====================
  // write-back and memory
  // ====================
  noZeroWrite: assert property (@(posedge clk) disable iff (!rst) wbWrite |-> wbAddr != 5'd0)
    else $error("wbWrite set with wbAddr zero");

  writeHasEn: assert property (@(posedge clk) disable iff (!rst) dmem.write |-> dmem.en)
    else $error("dmem write strobe without enable");

endmodule

bind mipsCore mipsCoreSva sva_i (
  .clk      (clk),
  .rst      (rst),
  .imemAddr (imemAddr),
  .dmem     (dmem),
  .wbWrite  (wbWrite),
  .wbAddr   (wbAddr)
);
